// File: hdl/ps2_pkg.sv
/*
 * PS/2 protocol constants and frame sizes for the keyboard front end.
 * Modules that talk to the PS/2 line import this package in their header.
 */
`default_nettype none

package ps2_pkg;

	localparam int PS2_BYTE_W  = 8;
	localparam int PS2_FRAME_W = 11;	// start, 8 data, parity, stop

	typedef logic [PS2_BYTE_W-1:0] ps2_byte_t;

	// host command
	localparam ps2_byte_t PS2_CMD_SET_LEDS = 8'hED;

	// keyboard prefix and reply codes
	localparam ps2_byte_t PS2_CODE_EXTENDED = 8'hE0;
	localparam ps2_byte_t PS2_CODE_RELEASE  = 8'hF0;
	localparam ps2_byte_t PS2_CODE_ACK      = 8'hFA;

endpackage

`default_nettype wire

// File: hdl/amiga_key_pkg.sv
/*
 * Amiga side definitions: the raw key word handed to the host and the
 * keymap table word, which is either a key entry or a PS/2 prefix entry.
 */
`default_nettype none

package amiga_key_pkg;

	localparam int AKEY_CODE_W = 7;

	// bit 7 set on release, raw key code below
	typedef logic [AKEY_CODE_W:0] akey_t;

	//--------------------------------------------------
	// keymap table word
	//--------------------------------------------------
	typedef struct packed {
		logic                   valid;		// maps to an Amiga key
		logic                   ctrl;
		logic                   alt_left;
		logic                   alt_right;
		logic                   caps;
		logic                   numlock;	// toggles numlock, no key code
		logic                   keypad;		// blocked while numlock is on
		logic                   spare;
		logic                   is_prefix;	// clear in a key entry
		logic [AKEY_CODE_W-1:0] code;
	} keymap_key_t;

	typedef struct packed {
		logic [7:0] spare;
		logic       is_prefix;
		logic [3:0] pad;
		logic       is_ack;
		logic       is_rel;
		logic       is_ext;
	} keymap_prefix_t;

	// one table word, decoded as a key or as a prefix
	typedef union packed {
		keymap_key_t    key;
		keymap_prefix_t prefix;
	} keymap_entry_u;

endpackage

`default_nettype wire

// File: hdl/ps2_link.sv
/*
 * PS/2 line interface. Drives clock and data open-collector, synchronizes
 * both lines and moves receive and send frames on falling clock edges.
 * The session controller steers it through clk_release and the load pulses.
 */
`default_nettype none
`timescale 1ns/1ps

module ps2_link
	import ps2_pkg::*;
(
	input  logic      clk,
	input  logic      clk_release,	// low holds the PS/2 clock low
	input  logic      rx_clear,
	input  logic      load_cmd,
	input  logic      load_leds,
	input  logic      capslock,
	input  logic      numlock,
	input  logic      ledb,
	inout  wire       ps2kclk,
	inout  wire       ps2kdat,
	output ps2_byte_t rx_byte,
	output logic      rx_ready,
	output logic      rx_busy,
	output logic      tx_done
);

	localparam int SHIFT_W = PS2_FRAME_W + 1;	// frame plus sentinel

	logic [1:0]         clk_sync;	// [0] newest sample
	logic               dat_sync;
	logic               clk_fall;
	logic [SHIFT_W-1:0] rx_shift;
	logic [SHIFT_W-1:0] tx_shift;
	logic [2:0]         led_bits;

	// open-collector drivers, released means pulled up outside
	assign ps2kclk = clk_release ? 1'bz : 1'b0;
	assign ps2kdat = tx_shift[0] ? 1'bz : 1'b0;

	always_ff @(posedge clk)
	begin
		clk_sync <= {clk_sync[0], ps2kclk};
		dat_sync <= ps2kdat;
	end

	// edges caused by our own clock hold are ignored
	assign clk_fall = clk_sync[1] & ~clk_sync[0] & clk_release;

	//--------------------------------------------------
	// receive, a zero walks down to bit 0 when full
	//--------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rx_clear || rx_ready)
			rx_shift <= '1;
		else if (clk_fall)
			rx_shift <= {1'b0, dat_sync, rx_shift[SHIFT_W-2:1]};
	end

	assign rx_ready = ~rx_shift[0];
	assign rx_busy  = ~rx_shift[SHIFT_W-1];	// first bit already in
	assign rx_byte  = rx_shift[PS2_BYTE_W:1];

	//--------------------------------------------------
	// send, start bit sits on the line during request-to-send
	//--------------------------------------------------
	assign led_bits = {capslock, numlock, ledb};

	always_ff @(posedge clk)
	begin
		if (load_cmd)
			tx_shift <= {2'b11, ~^PS2_CMD_SET_LEDS, PS2_CMD_SET_LEDS, 1'b0};
		else if (load_leds)
			tx_shift <= {2'b11, ~^led_bits, 5'b00000, led_bits, 1'b0};	// odd parity
		else if (clk_fall && !tx_done)
			tx_shift <= {1'b0, tx_shift[SHIFT_W-1:1]};
	end

	assign tx_done = (tx_shift == SHIFT_W'(1));

	// command and LED frames never compete for the send shifter
	a_single_load: assert property (@(posedge clk)
		!(load_cmd === 1'b1 && load_leds === 1'b1));

endmodule

`default_nettype wire

// File: hdl/ps2_session_ctrl.sv
/*
 * Session controller for the PS/2 keyboard. Sends the LED command and LED
 * byte after reset and after each idle timeout, then passes keys through
 * and holds the keyboard off after every key until keyack or timeout.
 */
`default_nettype none
`timescale 1ns/1ps

module ps2_session_ctrl #(
	parameter int TIMER_SHORT_BIT = 15,
	parameter int TIMER_LONG_BIT  = 19
) (
	input  logic clk,
	input  logic reset,
	input  logic rx_ready,
	input  logic rx_busy,
	input  logic tx_done,
	input  logic keystrobe,
	input  logic keyack,
	output logic clk_release,
	output logic rx_clear,
	output logic load_cmd,
	output logic load_leds
);

	typedef enum logic [2:0] {
		ST_RESET,	// clear timer, load 0xED
		ST_CMD_RTS,	// request-to-send for the command
		ST_CMD_WAIT,	// command out, wait for 0xFA
		ST_LED_RTS,
		ST_LED_WAIT,
		ST_IDLE,	// waiting for a key
		ST_HOLD		// keyboard inhibited
	} state_t;

	state_t                  state;
	state_t                  state_next;
	logic [TIMER_LONG_BIT:0] timer;
	logic                    timer_clear;
	logic                    timer_short;
	logic                    timer_long;

	//--------------------------------------------------
	// timer, stops once the long bit sets
	//--------------------------------------------------
	assign timer_short = timer[TIMER_SHORT_BIT];
	assign timer_long  = timer[TIMER_LONG_BIT];

	always_ff @(posedge clk)
	begin
		if (reset || timer_clear)
			timer <= '0;
		else if (!timer_long)
			timer <= timer + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_RESET;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next  = state;
		clk_release = 1'b1;
		rx_clear    = 1'b0;
		timer_clear = 1'b0;
		load_cmd    = 1'b0;
		load_leds   = 1'b0;
		case (state)
			ST_RESET:
			begin
				clk_release = 1'b0;
				rx_clear    = 1'b1;
				timer_clear = 1'b1;
				load_cmd    = 1'b1;
				state_next  = ST_CMD_RTS;
			end
			ST_CMD_RTS, ST_LED_RTS:
			begin
				clk_release = 1'b0;
				rx_clear    = 1'b1;
				if (timer_short)
					state_next = (state == ST_CMD_RTS) ? ST_CMD_WAIT : ST_LED_WAIT;
			end
			ST_CMD_WAIT, ST_LED_WAIT:
			begin
				rx_clear    = ~tx_done;	// keep our own frame out of the receiver
				timer_clear = 1'b1;
				if (rx_ready)
				begin
					load_leds  = (state == ST_CMD_WAIT);
					state_next = (state == ST_CMD_WAIT) ? ST_LED_RTS : ST_IDLE;
				end
			end
			ST_IDLE:
			begin
				timer_clear = keystrobe || rx_ready;	// idle time counts from the last frame
				if (keystrobe)
					state_next = ST_HOLD;
				else if (!rx_busy && timer_long)
					state_next = ST_RESET;	// refresh LEDs
			end
			ST_HOLD:
			begin
				clk_release = 1'b0;
				timer_clear = keyack;
				if (keyack || timer_long)
					state_next = ST_IDLE;
			end
			default:
				state_next = ST_RESET;
		endcase
	end

	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {ST_RESET, ST_CMD_RTS, ST_CMD_WAIT, ST_LED_RTS,
			ST_LED_WAIT, ST_IDLE, ST_HOLD});

endmodule

`default_nettype wire

// File: hdl/scancode_mapper.sv
/*
 * Scan code set 2 to Amiga raw key mapper. A registered table lookup
 * indexed by the extended flag and the scan code, followed by prefix
 * tracking, numlock handling and a register stage for key_valid.
 */
`default_nettype none
`timescale 1ns/1ps

module scancode_mapper
	import ps2_pkg::*;
	import amiga_key_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  ps2_byte_t rx_byte,
	input  logic      rx_ready,
	output logic      key_valid,
	output akey_t     key_word,
	output logic      ctrl,
	output logic      alt_left,
	output logic      alt_right,
	output logic      caps,
	output logic      numlock
);

	keymap_entry_u entry;		// table word, one cycle after rx_ready
	logic          entry_en;
	logic          ext_seen;	// E0 received
	logic          rel_seen;	// F0 received
	logic          is_key;
	logic          pfx_ext;
	logic          pfx_rel;
	logic          pfx_ack;

	always_ff @(posedge clk)
	begin
		if (reset)
			entry_en <= 1'b0;
		else
			entry_en <= rx_ready;
	end

	assign is_key  = entry_en && !entry.key.is_prefix;
	assign pfx_ext = entry_en && entry.prefix.is_prefix && entry.prefix.is_ext;
	assign pfx_rel = entry_en && entry.prefix.is_prefix && entry.prefix.is_rel;
	assign pfx_ack = entry_en && entry.prefix.is_prefix && entry.prefix.is_ack;

	// an ack from the keyboard leaves pending prefixes alone
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ext_seen <= 1'b0;
			rel_seen <= 1'b0;
		end
		else if (pfx_ext)
			ext_seen <= 1'b1;
		else if (pfx_rel)
			rel_seen <= 1'b1;
		else if (entry_en && !pfx_ack)
		begin
			ext_seen <= 1'b0;
			rel_seen <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			numlock <= 1'b0;
		else if (is_key && entry.key.numlock && !rel_seen)
			numlock <= ~numlock;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			key_valid <= 1'b0;
		else
			key_valid <= is_key && entry.key.valid && !(entry.key.keypad && numlock);
	end

	always_ff @(posedge clk)
	begin
		key_word  <= {rel_seen, entry.key.code};
		ctrl      <= entry.key.ctrl;
		alt_left  <= entry.key.alt_left;
		alt_right <= entry.key.alt_right;
		caps      <= entry.key.caps;
	end

	//--------------------------------------------------
	// keymap, {extended, scan code}, empty unless listed
	//--------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rx_ready)
		begin
			case ({ext_seen, rx_byte})
				9'h016:	entry <= 16'h8001;	// 1
				9'h01e:	entry <= 16'h8002;	// 2
				9'h026:	entry <= 16'h8003;
				9'h025:	entry <= 16'h8004;
				9'h02e:	entry <= 16'h8005;
				9'h036:	entry <= 16'h8006;
				9'h03d:	entry <= 16'h8007;
				9'h03e:	entry <= 16'h8008;
				9'h046:	entry <= 16'h8009;
				9'h045:	entry <= 16'h800a;	// 0
				9'h015:	entry <= 16'h8010;	// q
				9'h01d:	entry <= 16'h8011;
				9'h024:	entry <= 16'h8012;
				9'h02d:	entry <= 16'h8013;
				9'h02c:	entry <= 16'h8014;
				9'h035:	entry <= 16'h8015;
				9'h03c:	entry <= 16'h8016;
				9'h043:	entry <= 16'h8017;
				9'h044:	entry <= 16'h8018;
				9'h04d:	entry <= 16'h8019;	// p
				9'h01c:	entry <= 16'h8020;	// a
				9'h01b:	entry <= 16'h8021;
				9'h023:	entry <= 16'h8022;
				9'h02b:	entry <= 16'h8023;
				9'h034:	entry <= 16'h8024;
				9'h033:	entry <= 16'h8025;
				9'h03b:	entry <= 16'h8026;
				9'h042:	entry <= 16'h8027;
				9'h04b:	entry <= 16'h8028;	// l
				9'h01a:	entry <= 16'h8031;	// z
				9'h022:	entry <= 16'h8032;
				9'h021:	entry <= 16'h8033;
				9'h02a:	entry <= 16'h8034;
				9'h032:	entry <= 16'h8035;
				9'h031:	entry <= 16'h8036;
				9'h03a:	entry <= 16'h8037;	// m
				9'h029:	entry <= 16'h8040;	// space
				9'h066:	entry <= 16'h8041;	// backspace
				9'h00d:	entry <= 16'h8042;	// tab
				9'h05a:	entry <= 16'h8044;	// return
				9'h076:	entry <= 16'h8045;	// escape
				9'h012:	entry <= 16'h8060;	// left shift
				9'h059:	entry <= 16'h8061;	// right shift
				9'h058:	entry <= 16'h8862;	// capslock
				9'h014:	entry <= 16'hc063;	// ctrl
				9'h011:	entry <= 16'ha064;	// left alt
				9'h111:	entry <= 16'h9065;	// right alt
				9'h11f:	entry <= 16'h8066;	// left amiga
				9'h127:	entry <= 16'h8067;	// right amiga
				9'h077:	entry <= 16'h0400;	// numlock, toggle only
				9'h070:	entry <= 16'h820f;	// keypad 0
				9'h069:	entry <= 16'h821d;	// keypad 1
				9'h072:	entry <= 16'h821e;
				9'h06b:	entry <= 16'h822d;	// keypad 4
				9'h075:	entry <= 16'h823e;	// keypad 8
				9'h175:	entry <= 16'h804c;	// cursor up
				9'h172:	entry <= 16'h804d;
				9'h174:	entry <= 16'h804e;
				9'h16b:	entry <= 16'h804f;	// cursor left
				{1'b0, PS2_CODE_EXTENDED}, {1'b1, PS2_CODE_EXTENDED}:
					entry <= 16'h0081;
				{1'b0, PS2_CODE_RELEASE}, {1'b1, PS2_CODE_RELEASE}:
					entry <= 16'h0082;
				{1'b0, PS2_CODE_ACK}, {1'b1, PS2_CODE_ACK}:
					entry <= 16'h0084;
				default:
					entry <= 16'h0000;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/amiga_key_filter.sv
/*
 * Amiga key event filter. Drops typematic repeats, emulates the latching
 * Amiga capslock, raises keystrobe for each event that survives and
 * drives kbdrst while ctrl or caps and both alt keys are held.
 */
`default_nettype none
`timescale 1ns/1ps

module amiga_key_filter
	import amiga_key_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  key_valid,
	input  akey_t key_word,
	input  logic  ctrl,
	input  logic  alt_left,
	input  logic  alt_right,
	input  logic  caps,
	output logic  keystrobe,
	output akey_t keydat,
	output logic  capslock,
	output logic  kbdrst
);

	akey_t      last_key;	// last press, or its own release
	logic       same_code;
	logic       repeat_evt;
	logic [2:0] key_hit;	// ctrl or caps, left alt, right alt
	logic [2:0] key_held;

	assign same_code  = (last_key[AKEY_CODE_W-1:0] == key_word[AKEY_CODE_W-1:0]);
	assign repeat_evt = same_code && (last_key[AKEY_CODE_W] == key_word[AKEY_CODE_W]);

	always_ff @(posedge clk)
	begin
		if (reset)
			last_key <= '0;
		else if (key_valid && (!key_word[AKEY_CODE_W] || same_code))
			last_key <= key_word;
	end

	// toggles on a fresh caps press only
	always_ff @(posedge clk)
	begin
		if (reset)
			capslock <= 1'b0;
		else if (key_valid && caps && !key_word[AKEY_CODE_W] && !repeat_evt)
			capslock <= ~capslock;
	end

	// with capslock set, all caps events are swallowed
	assign keystrobe = key_valid && !(capslock && caps) && !repeat_evt;
	assign keydat    = key_word;

	//--------------------------------------------------
	// reset combination
	//--------------------------------------------------
	assign key_hit = {ctrl | caps, alt_left, alt_right};

	always_ff @(posedge clk)
	begin
		if (reset)
			key_held <= '0;
		else
			for (int i = 0; i < 3; i++)
				if (key_valid && key_hit[i])
					key_held[i] <= !key_word[AKEY_CODE_W];
	end

	assign kbdrst = &key_held;

	// one strobe per mapped key event
	a_strobe_pulse: assert property (@(posedge clk) disable iff (reset)
		keystrobe |-> key_valid ##1 !keystrobe);

endmodule

`default_nettype wire

// File: hdl/ps2_keyboard_top.sv
/*
 * PS/2 keyboard front end for an Amiga-style host. Connect ps2kclk and
 * ps2kdat to the pulled-up PS/2 lines; keydat is valid while keystrobe is
 * high and the host answers each key with a keyack pulse.
 */
`default_nettype none
`timescale 1ns/1ps

module ps2_keyboard_top
	import ps2_pkg::*;
	import amiga_key_pkg::*;
#(
	parameter int TIMER_SHORT_BIT = 15,	// request-to-send hold
	parameter int TIMER_LONG_BIT  = 19	// idle and keyack timeout
) (
	input  logic  clk,
	input  logic  reset,
	inout  wire   ps2kclk,
	inout  wire   ps2kdat,
	input  logic  ledb,
	input  logic  keyack,
	output akey_t keydat,
	output logic  keystrobe,
	output logic  capslock,
	output logic  kbdrst
);

	// link and controller
	logic      clk_release;
	logic      rx_clear;
	logic      load_cmd;
	logic      load_leds;
	ps2_byte_t rx_byte;
	logic      rx_ready;
	logic      rx_busy;
	logic      tx_done;

	// mapper to filter
	logic      key_valid;
	akey_t     key_word;
	logic      ctrl;
	logic      alt_left;
	logic      alt_right;
	logic      caps;
	logic      numlock;

	ps2_link i_link (
		.clk         (clk),
		.clk_release (clk_release),
		.rx_clear    (rx_clear),
		.load_cmd    (load_cmd),
		.load_leds   (load_leds),
		.capslock    (capslock),
		.numlock     (numlock),
		.ledb        (ledb),
		.ps2kclk     (ps2kclk),
		.ps2kdat     (ps2kdat),
		.rx_byte     (rx_byte),
		.rx_ready    (rx_ready),
		.rx_busy     (rx_busy),
		.tx_done     (tx_done)
	);

	ps2_session_ctrl #(
		.TIMER_SHORT_BIT (TIMER_SHORT_BIT),
		.TIMER_LONG_BIT  (TIMER_LONG_BIT)
	) i_ctrl (
		.clk         (clk),
		.reset       (reset),
		.rx_ready    (rx_ready),
		.rx_busy     (rx_busy),
		.tx_done     (tx_done),
		.keystrobe   (keystrobe),
		.keyack      (keyack),
		.clk_release (clk_release),
		.rx_clear    (rx_clear),
		.load_cmd    (load_cmd),
		.load_leds   (load_leds)
	);

	scancode_mapper i_mapper (
		.clk       (clk),
		.reset     (reset),
		.rx_byte   (rx_byte),
		.rx_ready  (rx_ready),
		.key_valid (key_valid),
		.key_word  (key_word),
		.ctrl      (ctrl),
		.alt_left  (alt_left),
		.alt_right (alt_right),
		.caps      (caps),
		.numlock   (numlock)
	);

	amiga_key_filter i_filter (
		.clk       (clk),
		.reset     (reset),
		.key_valid (key_valid),
		.key_word  (key_word),
		.ctrl      (ctrl),
		.alt_left  (alt_left),
		.alt_right (alt_right),
		.caps      (caps),
		.keystrobe (keystrobe),
		.keydat    (keydat),
		.capslock  (capslock),
		.kbdrst    (kbdrst)
	);

endmodule

`default_nettype wire

// File: tb/ps2_device_model.sv
/*
 * Behavioral PS/2 keyboard for the testbench. Queue bytes with queue_byte;
 * each goes out right after the keyboard acknowledges a host LED byte.
 * Host frames are answered with 0xFA and recorded in host_byte.
 */
`default_nettype none
`timescale 1ns/1ps

module ps2_device_model #(
	parameter int HALF_NS = 2000	// short enough for the host idle window
) (
	inout  wire  ps2kclk,
	inout  wire  ps2kdat,
	output logic fault
);

	logic       clk_low;
	logic       dat_low;
	logic [7:0] tx_queue[$];
	logic [7:0] host_byte[0:1023];
	logic       host_parity_ok[0:1023];
	int         host_count;
	int         sent_count;

	assign ps2kclk = clk_low ? 1'b0 : 1'bz;
	assign ps2kdat = dat_low ? 1'b0 : 1'bz;

	task queue_byte(input logic [7:0] b);
		tx_queue.push_back(b);
	endtask

	// host may inhibit us by holding the clock low
	task wait_clk_free;
		int cnt;
		cnt = 0;
		while (ps2kclk !== 1'b1 && cnt < 5000)
		begin
			#100;
			cnt++;
		end
		if (ps2kclk !== 1'b1)
		begin
			$display("device model: host held the clock low too long");
			fault = 1'b1;
		end
	endtask

	task wait_request;
		int cnt;
		cnt = 0;
		while (ps2kdat !== 1'b0 && cnt < 10000)
		begin
			#100;
			cnt++;
		end
		if (ps2kdat !== 1'b0)
		begin
			$display("device model: no request-to-send from the host");
			fault = 1'b1;
		end
	endtask

	task send_frame(input logic [7:0] b);
		logic [10:0] bits;
		bits = {1'b1, ~^b, b, 1'b0};	// stop, odd parity, data, start
		wait_clk_free;
		for (int i = 0; i < 11; i++)
		begin
			dat_low = !bits[i];
			#(HALF_NS/2);
			clk_low = 1'b1;
			#HALF_NS;
			clk_low = 1'b0;
			#(HALF_NS/2);
		end
		dat_low = 1'b0;
	endtask

	task receive_frame(output logic [7:0] b, output logic ok);
		logic [9:0] bits;
		wait_clk_free;
		for (int i = 0; i < 10; i++)
		begin
			#HALF_NS;
			clk_low = 1'b1;
			#HALF_NS;
			bits[i] = ps2kdat;	// data, parity, stop
			clk_low = 1'b0;
		end
		// acknowledge bit
		#(HALF_NS/2);
		dat_low = 1'b1;
		#(HALF_NS/2);
		clk_low = 1'b1;
		#HALF_NS;
		clk_low = 1'b0;
		#(HALF_NS/2);
		dat_low = 1'b0;
		b  = bits[7:0];
		ok = (^bits[8:0]) && bits[9];
	endtask

	initial
	begin
		logic [7:0] b;
		logic       ok;
		logic       prev_cmd;
		logic       is_led;
		clk_low    = 1'b0;
		dat_low    = 1'b0;
		fault      = 1'b0;
		host_count = 0;
		sent_count = 0;
		prev_cmd   = 1'b0;
		forever
		begin
			wait_request;
			receive_frame(b, ok);
			host_byte[host_count % 1024]      = b;
			host_parity_ok[host_count % 1024] = ok;
			host_count++;
			send_frame(8'hFA);
			is_led   = prev_cmd;
			prev_cmd = (b == 8'hED);
			if (is_led && tx_queue.size() > 0)
			begin
				send_frame(tx_queue.pop_front());
				sent_count++;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/ps2_keyboard_tb.sv
/*
 * Testbench for the PS/2 keyboard front end. Drives scan codes through the
 * device model and checks keydat, capslock, kbdrst and the LED bytes.
 */
`default_nettype none
`timescale 1ns/1ps

module ps2_keyboard_tb;

	localparam int WAIT_LIMIT = 100000;

	logic       clk;
	logic       reset;
	logic       ledb;
	logic       keyack;
	wire        ps2kclk;
	wire        ps2kdat;
	logic [7:0] keydat;
	logic       keystrobe;
	logic       capslock;
	logic       kbdrst;
	logic       model_fault;
	logic [31:0] lfsr_state;
	logic [7:0] strobe_q[$];
	int         ack_delay = 0;

	pullup (ps2kclk);
	pullup (ps2kdat);

	ps2_keyboard_top #(
		.TIMER_SHORT_BIT (6),
		.TIMER_LONG_BIT  (10)
	) i_dut (
		.clk       (clk),
		.reset     (reset),
		.ps2kclk   (ps2kclk),
		.ps2kdat   (ps2kdat),
		.ledb      (ledb),
		.keyack    (keyack),
		.keydat    (keydat),
		.keystrobe (keystrobe),
		.capslock  (capslock),
		.kbdrst    (kbdrst)
	);

	ps2_device_model i_model (
		.ps2kclk (ps2kclk),
		.ps2kdat (ps2kdat),
		.fault   (model_fault)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	//--------------------------------------------------
	// strobe capture and keyack
	//--------------------------------------------------
	always @(negedge clk)
	begin
		if (keystrobe === 1'b1)
		begin
			strobe_q.push_back(keydat);
			ack_delay = 3;
		end
	end

	always @(posedge clk)
	begin
		#1;
		if (ack_delay > 0)
			ack_delay = ack_delay - 1;
		keyack = (ack_delay == 1);
	end

	task report_failure(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	always @(posedge model_fault)
		report_failure("the PS/2 device model timed out waiting for the host");

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task random_bits(input int n, output int r);
		r = 0;
		for (int i = 0; i < n; i++)
		begin
			r = (r << 1) | lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// LED byte: caps in bit 2, numlock in bit 1, ledb in bit 0
	function automatic logic [7:0] led_byte(input logic c, input logic n, input logic l);
		return {5'b00000, c, n, l};
	endfunction

	task check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
		else
			report_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	// waits until the byte is out and the LED update after it is done
	task send_code(input logic [7:0] code);
		int gap;
		int cnt;
		int sent_before;
		int host_before;
		random_bits(4, gap);
		repeat (gap + 1) @(posedge clk);
		#1;
		sent_before = i_model.sent_count;
		i_model.queue_byte(code);
		cnt = 0;
		while (i_model.sent_count == sent_before && cnt < WAIT_LIMIT)
		begin
			@(posedge clk);
			cnt++;
		end
		if (i_model.sent_count == sent_before)
			report_failure($sformatf("timeout: scan code %h was never sent", code));
		host_before = i_model.host_count;
		cnt = 0;
		while (i_model.host_count < host_before + 2 && cnt < WAIT_LIMIT)
		begin
			@(posedge clk);
			cnt++;
		end
		if (i_model.host_count < host_before + 2)
			report_failure("timeout: no LED update followed the scan code");
		repeat (2) @(posedge clk);
	endtask

	task expect_key(input string name, input logic [7:0] exp);
		check_value({name, " strobes"}, 8'd1, 8'(strobe_q.size()));
		check_value(name, exp, strobe_q.pop_front());
	endtask

	task expect_none(input string name);
		check_value({name, " strobes"}, 8'd0, 8'(strobe_q.size()));
	endtask

	task check_led(input string name, input logic [7:0] exp);
		int idx;
		idx = (i_model.host_count - 1) % 1024;
		check_value(name, exp, i_model.host_byte[idx]);
		check_value({name, " parity"}, 8'd1, 8'(i_model.host_parity_ok[idx]));
	endtask

	initial
	begin
		int cnt;
		reset      = 1'b1;
		ledb       = 1'b1;
		keyack     = 1'b0;
		lfsr_state = 32'ha906bc17;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;

		// LED update after reset
		cnt = 0;
		while (i_model.host_count < 2 && cnt < WAIT_LIMIT)
		begin
			@(posedge clk);
			cnt++;
		end
		if (i_model.host_count < 2)
			report_failure("timeout: no LED update after reset");
		check_value("led command", 8'hED, i_model.host_byte[0]);
		check_value("led byte", led_byte(1'b0, 1'b0, 1'b1), i_model.host_byte[1]);
		check_value("led parity", 8'd1, 8'(i_model.host_parity_ok[0] & i_model.host_parity_ok[1]));
		expect_none("after reset");
		check_value("kbdrst after reset", 8'd0, 8'(kbdrst));

		// translation
		send_code(8'h1C);
		expect_key("press a", 8'h20);
		send_code(8'hF0);
		send_code(8'h1C);
		expect_key("release a", 8'hA0);
		send_code(8'hE0);
		send_code(8'h75);
		expect_key("press cursor up", 8'h4C);
		send_code(8'hE0);
		send_code(8'hF0);
		send_code(8'h75);
		expect_key("release cursor up", 8'hCC);

		// typematic
		send_code(8'h1C);
		expect_key("first press", 8'h20);
		send_code(8'h1C);
		expect_none("repeat one");
		send_code(8'h1C);
		expect_none("repeat two");
		send_code(8'hF0);
		send_code(8'h1C);
		expect_key("release after repeat", 8'hA0);
		send_code(8'h1C);
		expect_key("press after release", 8'h20);
		send_code(8'hF0);
		send_code(8'h1C);
		expect_key("release again", 8'hA0);

		// capslock
		send_code(8'h58);
		expect_key("caps press", 8'h62);
		check_value("capslock set", 8'd1, 8'(capslock));
		check_led("led with caps", led_byte(1'b1, 1'b0, 1'b1));
		send_code(8'hF0);
		send_code(8'h58);
		expect_none("caps release held");
		send_code(8'h58);
		expect_none("caps second press");
		check_value("capslock clear", 8'd0, 8'(capslock));
		send_code(8'hF0);
		send_code(8'h58);
		expect_key("caps release", 8'hE2);
		check_led("led without caps", led_byte(1'b0, 1'b0, 1'b1));

		// numlock
		send_code(8'h69);
		expect_key("keypad 1", 8'h1D);
		send_code(8'hF0);
		send_code(8'h69);
		expect_key("keypad 1 release", 8'h9D);
		send_code(8'h77);
		expect_none("numlock press");
		send_code(8'hF0);
		send_code(8'h77);
		expect_none("numlock release");
		check_led("led with numlock", led_byte(1'b0, 1'b1, 1'b1));
		send_code(8'h69);
		expect_none("keypad blocked");
		send_code(8'hF0);
		send_code(8'h69);
		expect_none("keypad release blocked");

		// reset combination
		send_code(8'h14);
		expect_key("ctrl", 8'h63);
		send_code(8'h11);
		expect_key("left alt", 8'h64);
		check_value("kbdrst two keys", 8'd0, 8'(kbdrst));
		send_code(8'hE0);
		send_code(8'h11);
		expect_key("right alt", 8'h65);
		check_value("kbdrst three keys", 8'd1, 8'(kbdrst));
		send_code(8'hF0);
		send_code(8'h11);
		expect_key("left alt release", 8'hE4);
		check_value("kbdrst released", 8'd0, 8'(kbdrst));

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hdl/ps2_pkg.sv
hdl/amiga_key_pkg.sv
hdl/ps2_link.sv
hdl/ps2_session_ctrl.sv
hdl/scancode_mapper.sv
hdl/amiga_key_filter.sv
hdl/ps2_keyboard_top.sv
tb/ps2_device_model.sv
tb/ps2_keyboard_tb.sv
